//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = move_gen_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qxF "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- files.f
source/move_gen_pkg.sv
source/castle_detect.sv
source/en_passant_detect.sv
source/move_fifo.sv
source/move_gen_control.sv
source/move_gen_top.sv
verification/move_gen_tb.sv

//--- source/castle_detect.sv
module castle_detect
	import move_gen_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic capture,
	input board_t board,
	input logic kingside_ok,
	input logic queenside_ok,
	output move_batch_t batch
);

	logic king_home;
	logic kingside;
	logic queenside;
	logic [MAX_SLOTS-1:0] valid_q;
	move_t [MAX_SLOTS-1:0] slots;

	// squares under attack are not checked
	assign king_home = board[SQ_E1] == WHITE_KING;

	assign kingside = king_home && kingside_ok
		&& board[SQ_H1] == WHITE_ROOK
		&& board[SQ_F1].piece == EMPTY
		&& board[SQ_G1].piece == EMPTY;

	assign queenside = king_home && queenside_ok
		&& board[SQ_A1] == WHITE_ROOK
		&& board[SQ_B1].piece == EMPTY
		&& board[SQ_C1].piece == EMPTY
		&& board[SQ_D1].piece == EMPTY;

	// the two moves never change, only their valid bits do
	always_comb begin
		for (int s = 0; s < MAX_SLOTS; s++) begin
			slots[s] = INVALID_MOVE;
		end
		slots[0] = '{flag: CASTLE_FLAG, from: COORD_E1, to: COORD_G1};
		slots[1] = '{flag: CASTLE_FLAG, from: COORD_E1, to: COORD_C1};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
		end else if (capture) begin
			valid_q <= {{(MAX_SLOTS-2){1'b0}}, queenside, kingside};
		end
	end

	assign batch = '{slots: slots, slot_valid: valid_q};

endmodule

//--- source/en_passant_detect.sv
module en_passant_detect
	import move_gen_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic capture,
	input board_t board,
	input logic [7:0] files, // bit 0 is file a
	output move_batch_t batch
);

	move_t [MAX_SLOTS-1:0] moves_next;
	logic [MAX_SLOTS-1:0] valid_next;
	move_t [MAX_SLOTS-1:0] moves_q;
	logic [MAX_SLOTS-1:0] valid_q;

	// slot s belongs to target file (s+1)/2
	// even slots hold the attacker on the right, odd slots the one on the left
	always_comb begin
		int target;
		int attacker;

		target = 0;
		attacker = 0;
		valid_next = '0;
		for (int s = 0; s < MAX_SLOTS; s++) begin
			moves_next[s] = INVALID_MOVE;
		end

		for (int s = 0; s < EP_SLOTS; s++) begin
			target = (s + 1) / 2;
			if (s % 2 == 0) begin
				attacker = target + 1;
			end else begin
				attacker = target - 1;
			end

			moves_next[s] = '{
				flag: EN_PASSANT_FLAG,
				from: '{file: 3'(attacker), rank: EP_FROM_RANK},
				to: '{file: 3'(target), rank: EP_TO_RANK}
			};
			valid_next[s] = files[target] && board[RANK5_BASE + attacker] == WHITE_PAWN;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
		end else if (capture) begin
			valid_q <= valid_next;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			moves_q <= moves_next;
		end
	end

	assign batch = '{slots: moves_q, slot_valid: valid_q};

endmodule

//--- source/move_fifo.sv
module move_fifo
	import move_gen_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic wr_en,
	input move_t wr_data,
	output logic full,
	input logic rd,
	output move_t rd_data,
	output logic empty
);

	move_t mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W:0] count;
	logic do_wr;
	logic do_rd;

	assign full = count == (FIFO_PTR_W + 1)'(FIFO_DEPTH);
	assign empty = count == '0;

	assign do_wr = wr_en && !full;
	assign do_rd = rd && !empty; // reads on empty are dropped

	// head of queue falls through
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps by itself
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// the writer sits in another module and must honour full
	no_write_when_full: assert property (
		@(posedge clk) disable iff (reset) wr_en |-> !full
	);

	count_in_range: assert property (
		@(posedge clk) disable iff (reset) count <= (FIFO_PTR_W + 1)'(FIFO_DEPTH)
	);

endmodule

//--- source/move_gen_control.sv
module move_gen_control
	import move_gen_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	output logic capture,
	input move_batch_t castle_batch,
	input move_batch_t en_passant_batch,
	output logic wr_en,
	output move_t wr_data,
	input logic full,
	output logic done
);

	gen_state_e state;
	gen_state_e state_next;

	// slots already written in this run
	logic [MAX_SLOTS-1:0] castle_taken;
	logic [MAX_SLOTS-1:0] ep_taken;

	logic [MAX_SLOTS-1:0] castle_rem;
	logic [MAX_SLOTS-1:0] ep_rem;
	logic [MAX_SLOTS-1:0] castle_pick;
	logic [MAX_SLOTS-1:0] ep_pick;
	logic [SLOT_W-1:0] castle_idx;
	logic [SLOT_W-1:0] ep_idx;
	logic castle_wr;
	logic ep_wr;

	function automatic logic [SLOT_W-1:0] lowest_slot(input logic [MAX_SLOTS-1:0] mask);
		logic [SLOT_W-1:0] idx;

		idx = '0;
		for (int i = MAX_SLOTS - 1; i >= 0; i--) begin
			if (mask[i]) begin
				idx = SLOT_W'(i);
			end
		end
		return idx;
	endfunction

	assign castle_rem = castle_batch.slot_valid & ~castle_taken;
	assign ep_rem = en_passant_batch.slot_valid & ~ep_taken;

	assign castle_idx = lowest_slot(castle_rem);
	assign ep_idx = lowest_slot(ep_rem);

	// one write per cycle, held off while the queue is full
	assign castle_wr = state == CASTLE_OUT && castle_rem != '0 && !full;
	assign ep_wr = state == EN_PASSANT_OUT && ep_rem != '0 && !full;

	assign castle_pick = {{(MAX_SLOTS-1){1'b0}}, castle_wr} << castle_idx;
	assign ep_pick = {{(MAX_SLOTS-1){1'b0}}, ep_wr} << ep_idx;

	assign wr_en = castle_wr || ep_wr;
	assign wr_data = castle_wr ? castle_batch.slots[castle_idx]
		: en_passant_batch.slots[ep_idx];

	assign capture = state == CAPTURE;
	assign done = state == DONE;

	always_comb begin
		state_next = state;
		case (state)
			IDLE, DONE: begin
				if (start) begin
					state_next = CAPTURE;
				end
			end
			CAPTURE: state_next = CASTLE_OUT; // batches are registered at the end of this cycle
			CASTLE_OUT: begin
				if ((castle_rem & ~castle_pick) == '0) begin
					state_next = EN_PASSANT_OUT;
				end
			end
			EN_PASSANT_OUT: begin
				if ((ep_rem & ~ep_pick) == '0) begin
					state_next = DONE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			castle_taken <= '0;
			ep_taken <= '0;
		end else begin
			state <= state_next;
			if (state == CAPTURE) begin
				castle_taken <= '0;
				ep_taken <= '0;
			end else begin
				castle_taken <= castle_taken | castle_pick;
				ep_taken <= ep_taken | ep_pick;
			end
		end
	end

	// done only once every valid slot of both batches went to the queue
	all_slots_written: assert property (
		@(posedge clk) disable iff (reset) done |-> castle_rem == '0 && ep_rem == '0
	);

endmodule

//--- source/move_gen_pkg.sv
package move_gen_pkg;

	typedef enum logic [2:0] {
		EMPTY,
		PAWN,
		KNIGHT,
		BISHOP,
		ROOK,
		QUEEN,
		KING,
		UNUSED
	} piece_e;

	typedef struct packed {
		logic color; // white is 0
		piece_e piece;
	} square_t;

	// index is file + 8 * rank, a1 at 0
	typedef square_t [63:0] board_t;

	typedef struct packed {
		logic [2:0] file;
		logic [2:0] rank;
	} coord_t;

	// flag bits from high to low are invalid, promote, pawn move, pawn 2 sq, en passant, castle, capture
	typedef struct packed {
		logic [6:0] flag;
		coord_t from;
		coord_t to;
	} move_t;

	localparam logic [6:0] CASTLE_FLAG = 7'b0000010;
	localparam logic [6:0] EN_PASSANT_FLAG = 7'b0010101;
	localparam move_t INVALID_MOVE = '{flag: 7'b1000000, from: 6'o00, to: 6'o00};

	localparam int MAX_SLOTS = 16;
	localparam int SLOT_W = $clog2(MAX_SLOTS);
	localparam int EP_SLOTS = 14; // two attackers per target, minus the board edges

	typedef struct packed {
		move_t [MAX_SLOTS-1:0] slots;
		logic [MAX_SLOTS-1:0] slot_valid;
	} move_batch_t;

	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

	localparam logic WHITE = 1'b0;
	localparam square_t WHITE_PAWN = '{color: WHITE, piece: PAWN};
	localparam square_t WHITE_ROOK = '{color: WHITE, piece: ROOK};
	localparam square_t WHITE_KING = '{color: WHITE, piece: KING};

	// back rank squares
	localparam int SQ_A1 = 0;
	localparam int SQ_B1 = 1;
	localparam int SQ_C1 = 2;
	localparam int SQ_D1 = 3;
	localparam int SQ_E1 = 4;
	localparam int SQ_F1 = 5;
	localparam int SQ_G1 = 6;
	localparam int SQ_H1 = 7;
	localparam int RANK5_BASE = 32; // a5

	localparam coord_t COORD_C1 = '{file: 3'd2, rank: 3'd0};
	localparam coord_t COORD_E1 = '{file: 3'd4, rank: 3'd0};
	localparam coord_t COORD_G1 = '{file: 3'd6, rank: 3'd0};
	localparam logic [2:0] EP_FROM_RANK = 3'd4; // rank 5
	localparam logic [2:0] EP_TO_RANK = 3'd5; // rank 6

	typedef enum logic [2:0] {
		IDLE,
		CAPTURE,
		CASTLE_OUT,
		EN_PASSANT_OUT,
		DONE
	} gen_state_e;

endpackage

//--- source/move_gen_top.sv
module move_gen_top
	import move_gen_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input board_t board,
	input logic castle_kingside_ok,
	input logic castle_queenside_ok,
	input logic [7:0] en_passant_files,
	input logic move_rd,
	output move_t move_out,
	output logic move_empty,
	output logic done
);

	logic capture;
	move_batch_t castle_batch;
	move_batch_t en_passant_batch;
	logic wr_en;
	move_t wr_data;
	logic full;

	move_gen_control control0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.capture(capture),
		.castle_batch(castle_batch),
		.en_passant_batch(en_passant_batch),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.full(full),
		.done(done)
	);

	castle_detect castle0 (
		.clk(clk),
		.reset(reset),
		.capture(capture),
		.board(board),
		.kingside_ok(castle_kingside_ok),
		.queenside_ok(castle_queenside_ok),
		.batch(castle_batch)
	);

	en_passant_detect en_passant0 (
		.clk(clk),
		.reset(reset),
		.capture(capture),
		.board(board),
		.files(en_passant_files),
		.batch(en_passant_batch)
	);

	// user drains the queue one move per strobe
	move_fifo fifo0 (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.full(full),
		.rd(move_rd),
		.rd_data(move_out),
		.empty(move_empty)
	);

endmodule

//--- verification/move_gen_tb.sv
module move_gen_tb
	import move_gen_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	logic clk;
	logic reset;
	logic start;
	board_t board;
	logic castle_kingside_ok;
	logic castle_queenside_ok;
	logic [7:0] en_passant_files;
	logic move_rd;
	move_t move_out;
	logic move_empty;
	logic done;

	move_t exp_moves[$];
	int expected_len;
	int write_count;
	int mismatches;
	int assert_errors;
	int timeouts;
	int seed;
	int timeout_cycles;

	move_gen_top dut0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.board(board),
		.castle_kingside_ok(castle_kingside_ok),
		.castle_queenside_ok(castle_queenside_ok),
		.en_passant_files(en_passant_files),
		.move_rd(move_rd),
		.move_out(move_out),
		.move_empty(move_empty),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// queue writes since the last start
	always @(posedge clk) begin
		if (reset || start) begin
			write_count <= 0;
		end else if (dut0.wr_en) begin
			write_count <= write_count + 1;
		end
	end

	empty_after_reset: assert property (@(posedge clk) $fell(reset) |-> move_empty && !done)
		else begin
			assert_errors++;
			$display("queue not empty or done high right after reset at %0t", $time);
		end

	start_clears_done: assert property (@(posedge clk) disable iff (reset) start |=> !done)
		else begin
			assert_errors++;
			$display("done still high in the cycle after start at %0t", $time);
		end

	done_after_writes: assert property (
		@(posedge clk) disable iff (reset) done && !start |-> write_count == expected_len
	) else begin
		assert_errors++;
		$display("done high after %0d of %0d writes at %0t", write_count, expected_len, $time);
	end

	empty_read_holds: assert property (
		@(posedge clk) disable iff (reset) move_rd && move_empty && done |=> $stable(move_out)
	) else begin
		assert_errors++;
		$display("read on an empty queue changed the output at %0t", $time);
	end

	function automatic move_t make_move(input logic [6:0] flag, input int ff, input int fr,
		input int tf, input int tr);
		move_t m;

		m.flag = flag;
		m.from.file = 3'(ff);
		m.from.rank = 3'(fr);
		m.to.file = 3'(tf);
		m.to.rank = 3'(tr);
		return m;
	endfunction

	function automatic logic is_white(input square_t sq, input piece_e piece);
		return sq.color == 1'b0 && sq.piece == piece;
	endfunction

	// expected moves in the order the queue hands them out
	task automatic build_expected();
		int a;
		logic king_home;

		exp_moves.delete();
		king_home = is_white(board[4], KING);
		if (castle_kingside_ok && king_home && is_white(board[7], ROOK)
			&& board[5].piece == EMPTY && board[6].piece == EMPTY) begin
			exp_moves.push_back(make_move(CASTLE_FLAG, 4, 0, 6, 0));
		end
		if (castle_queenside_ok && king_home && is_white(board[0], ROOK) && board[1].piece == EMPTY
			&& board[2].piece == EMPTY && board[3].piece == EMPTY) begin
			exp_moves.push_back(make_move(CASTLE_FLAG, 4, 0, 2, 0));
		end
		for (int t = 0; t < 8; t++) begin
			for (int d = -1; d <= 1; d += 2) begin
				a = t + d;
				if (en_passant_files[t] && a >= 0 && a < 8 && is_white(board[32 + a], PAWN)) begin
					exp_moves.push_back(make_move(EN_PASSANT_FLAG, a, 4, t, 5)); // rank 5 to 6
				end
			end
		end
	endtask

	task automatic place(input int sq, input piece_e piece, input logic color);
		board[sq].color = color;
		board[sq].piece = piece;
	endtask

	task automatic clear_inputs();
		board = '0;
		castle_kingside_ok = 1'b0;
		castle_queenside_ok = 1'b0;
		en_passant_files = 8'h00;
	endtask

	task automatic random_board();
		logic [31:0] r;

		for (int sq = 0; sq < 64; sq++) begin
			r = $random(seed);
			if (r[4:3] == 2'b00) begin
				place(sq, piece_e'(r[2:0]), r[5]);
			end else begin
				place(sq, EMPTY, 1'b0);
			end
		end
		r = $random(seed);
		if (r[0]) place(SQ_E1, KING, 1'b0);
		if (r[1]) place(SQ_A1, ROOK, 1'b0);
		if (r[2]) place(SQ_H1, ROOK, 1'b0);
		for (int f = 0; f < 8; f++) begin
			if (r[8 + f]) place(RANK5_BASE + f, PAWN, 1'b0);
		end
		castle_kingside_ok = r[3];
		castle_queenside_ok = r[4];
		r = $random(seed);
		en_passant_files = r[7:0];
	endtask

	task automatic read_while_empty();
		@(posedge clk);
		#2;
		move_rd = 1'b1;
		@(posedge clk);
		#2;
		move_rd = 1'b0;
	endtask

	task automatic drain_moves(input string name);
		int idle;
		move_t expected;

		idle = 0;
		while (exp_moves.size() > 0 && idle < timeout_cycles) begin
			@(posedge clk);
			#2;
			move_rd = 1'b0;
			if (!move_empty) begin
				expected = exp_moves.pop_front();
				if (move_out !== expected) begin
					mismatches++;
					$display("FAIL %s: expected %h, actual %h", name, expected, move_out);
				end
				move_rd = 1'b1;
				idle = 0;
			end else if (done) begin
				mismatches++;
				$display("%s: run ended with %0d moves missing", name, exp_moves.size());
				exp_moves.delete();
			end else begin
				idle++;
			end
		end
		if (exp_moves.size() > 0) begin
			timeouts++;
			$display("%s: timed out waiting for the next move", name);
			exp_moves.delete();
		end
		idle = 0;
		@(posedge clk);
		#2;
		move_rd = 1'b0;
		while (!done && idle < timeout_cycles) begin
			@(posedge clk);
			#2;
			idle++;
		end
		if (!done) begin
			timeouts++;
			$display("%s: timed out waiting for done", name);
		end else if (!move_empty) begin
			mismatches++;
			$display("%s: queue holds a move beyond the expected list", name);
		end
	endtask

	// hold_cycles keeps the reader away so the queue fills up
	task automatic run_case(input string name, input int hold_cycles);
		build_expected();
		@(posedge clk);
		#2;
		start = 1'b1;
		expected_len = exp_moves.size();
		@(posedge clk);
		#2;
		start = 1'b0;
		if (hold_cycles > 0) begin
			repeat (hold_cycles) @(posedge clk);
			#2;
			if (done || move_empty) begin
				mismatches++;
				$display("%s: queue did not hold moves back while full", name);
			end
		end
		drain_moves(name);
	endtask

	initial begin
		seed = 6460;
		timeout_cycles = 200;
		mismatches = 0;
		assert_errors = 0;
		timeouts = 0;
		expected_len = 0;
		reset = 1'b1;
		start = 1'b0;
		move_rd = 1'b0;
		clear_inputs();
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;

		run_case("empty_board", 0);

		place(SQ_E1, KING, 1'b0);
		place(SQ_A1, ROOK, 1'b0);
		place(SQ_H1, ROOK, 1'b0);
		castle_kingside_ok = 1'b1;
		castle_queenside_ok = 1'b1;
		run_case("castle_both", 0);
		read_while_empty();
		place(SQ_D1, KNIGHT, 1'b0);
		run_case("castle_d1_filled", 0);
		place(SQ_D1, EMPTY, 1'b0);
		castle_queenside_ok = 1'b0;
		run_case("castle_no_queenside", 0);

		clear_inputs();
		place(RANK5_BASE + 2, PAWN, 1'b0); // c5
		place(RANK5_BASE + 4, PAWN, 1'b0); // e5
		en_passant_files = 8'b0000_1000;
		run_case("ep_file_d", 0);
		clear_inputs();
		place(RANK5_BASE + 1, PAWN, 1'b0);
		en_passant_files = 8'b0000_0001;
		run_case("ep_file_a", 0);
		clear_inputs();
		place(RANK5_BASE + 3, PAWN, 1'b0);
		place(RANK5_BASE + 6, PAWN, 1'b1); // black pawn beside f does not count
		en_passant_files = 8'b0010_0000;
		run_case("ep_no_attacker", 0);
		read_while_empty();

		clear_inputs();
		place(SQ_E1, KING, 1'b0);
		place(SQ_A1, ROOK, 1'b0);
		place(SQ_H1, ROOK, 1'b0);
		castle_kingside_ok = 1'b1;
		castle_queenside_ok = 1'b1;
		for (int f = 0; f < 8; f++) begin
			place(RANK5_BASE + f, PAWN, 1'b0);
		end
		en_passant_files = 8'hff;
		run_case("back_pressure", 20);

		for (int n = 0; n < 20; n++) begin
			random_board();
			run_case($sformatf("random_%0d", n), 0);
		end

		$display("summary: %0d mismatches, %0d assertion failures, %0d timeouts",
			mismatches, assert_errors, timeouts);
		if (mismatches + assert_errors + timeouts == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
